// File: design/ula_pkg.sv
// ULA shared definitions
// Bus widths, raster geometry, colour and keyboard types
package ula_pkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data widths
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [12:0] vram_addr_t;   // Byte address into 8 KB video RAM
    typedef logic [7:0]  byte_t;        // CPU and RAM data byte
    typedef logic [2:0]  colour_t;      // G R B
    typedef logic [3:0]  pixel_t;       // Bright above colour
    typedef logic [5:0]  key_code_t;    // Row * 5 + column
    typedef logic [4:0]  key_row_t;     // Active low, 0 = pressed

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster geometry, one pixel per clock
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [8:0] LINE_CLOCKS = 9'd448;  // Clocks per line
    localparam logic [8:0] FRAME_LINES = 9'd312;  // Lines per frame
    localparam logic [8:0] DISP_W      = 9'd256;  // Display width in pixels
    localparam logic [8:0] DISP_H      = 9'd192;  // Display height in lines

    // Sync positions
    localparam logic [8:0] HSYNC_START = 9'd304;
    localparam logic [8:0] HSYNC_END   = 9'd336;  // First column after hs
    localparam logic [8:0] VSYNC_LINE  = 9'd248;  // vs spans 4 lines from here

    // Frame interrupt width in clocks
    localparam logic [5:0] INT_CLOCKS  = 6'd32;

    // Attribute area follows the 6 KB bitmap
    localparam vram_addr_t ATTR_BASE   = 13'h1800;

    // Fetch column to display column
    localparam logic [8:0] PIXEL_LAG   = 9'd8;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video fetch sequence
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State names which byte shows on fetch_data in this cycle
    typedef enum logic [1:0] {
        IDLE,                           // Nothing returning
        BITMAP,                         // Bitmap byte on fetch_data
        ATTR                            // Attribute byte on fetch_data
    } vfetch_state_t;

endpackage

// File: design/ula_port.sv
// ULA I/O port FE
// Latches border, EAR and MIC on writes, builds the read byte
`timescale 1ns/1ps

module ula_port import ula_pkg::*; (
    input  logic      clk_cpu,
    input  logic      reset,
    input  logic [15:0] A,            // CPU address, A[0] low selects the ULA
    input  byte_t     D,              // CPU write data
    input  logic      io_we,          // One-cycle I/O write strobe
    input  logic      ear_in,         // Tape input bit
    input  key_row_t  key_row,        // Selected keyboard columns
    output colour_t   border,
    output logic      ear_out,
    output logic      mic_out,
    output byte_t     ula_data        // I/O read data
);

    logic port_sel;
    assign port_sel = ~A[0];          // Even ports only

    // Output latch
    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            border  <= '0;
            ear_out <= 1'b0;
            mic_out <= 1'b0;
        end else if (io_we && port_sel) begin
            border  <= D[2:0];
            mic_out <= D[3];
            ear_out <= D[4];          // Speaker
        end
    end

    // Bits 7 and 5 float high, bit 6 is EAR in
    assign ula_data = port_sel ? {1'b1, ear_in, 1'b1, key_row} : 8'hFF;

endmodule

// File: design/key_matrix.sv
// Keyboard matrix
// 8 half-rows of 5 keys, set by key events and read through A[15:8]
`timescale 1ns/1ps

module key_matrix import ula_pkg::*; (
    input  logic      clk_cpu,
    input  logic      reset,
    input  logic      key_event,      // One-cycle strobe
    input  key_code_t key_code,       // Row * 5 + column
    input  logic      key_down,       // 1 = pressed
    input  logic [7:0] row_select,    // A[15:8], low selects a half-row
    output key_row_t  key_row
);

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Key state, stored active low like the matrix columns
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    key_row_t rows [8];

    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            for (int r = 0; r < 8; r++) begin
                rows[r] <= '1;        // All released
            end
        end else if (key_event) begin
            // Decode row and column, codes 40 and up match nothing
            for (int r = 0; r < 8; r++) begin
                for (int c = 0; c < 5; c++) begin
                    if (key_code == key_code_t'(r * 5 + c)) begin
                        rows[r][c] <= ~key_down;
                    end
                end
            end
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Column read
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Several selected rows AND together, as the diodes would
    always_comb begin
        key_row = '1;                 // No row selected reads 1F
        for (int r = 0; r < 8; r++) begin
            if (!row_select[r]) begin
                key_row = key_row & rows[r];
            end
        end
    end

endmodule

// File: design/video_ram.sv
// Video RAM
// 8 KB single-port synchronous memory for bitmap and attributes
`timescale 1ns/1ps

module video_ram import ula_pkg::*; (
    input  logic       clk_cpu,
    input  logic       we,            // Write this edge
    input  vram_addr_t addr,
    input  byte_t      wdata,
    output byte_t      rdata          // Valid one cycle after addr
);

    // One byte per address, 8192 entries
    byte_t mem [0:(1 << $bits(vram_addr_t)) - 1];

    always_ff @(posedge clk_cpu) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];           // Old data on a write cycle
    end

endmodule

// File: design/vram_arbiter.sv
// Video RAM arbiter
// Display fetch always owns the RAM, the CPU waits for a free cycle
`timescale 1ns/1ps

module vram_arbiter import ula_pkg::*; (
    input  logic       clk_cpu,
    input  logic       reset,
    // CPU side, held until cpu_ack
    input  logic       cpu_req,
    input  logic       cpu_we,
    input  vram_addr_t cpu_addr,
    input  byte_t      cpu_wdata,
    // Video fetch side, never stalled
    input  logic       fetch_req,
    input  vram_addr_t fetch_addr,
    output logic       cpu_wait,
    output logic       cpu_ack,
    output byte_t      cpu_rdata,
    output byte_t      fetch_data,
    // RAM port
    output logic       ram_we,
    output vram_addr_t ram_addr,
    output byte_t      ram_wdata,
    input  byte_t      ram_rdata
);

    logic cpu_grant;
    logic fetch_served;               // Fetch owned the RAM last cycle

    // Request already served while ack is out, so no second grant
    assign cpu_grant = cpu_req && !fetch_req && !cpu_ack;
    assign cpu_wait  = cpu_req && !cpu_ack && fetch_req;    // Contended

    // RAM master select, video first
    assign ram_addr  = fetch_req ? fetch_addr : cpu_addr;
    assign ram_we    = cpu_grant && cpu_we;
    assign ram_wdata = cpu_wdata;

    // Remember who was served for the read return
    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            cpu_ack      <= 1'b0;
            fetch_served <= 1'b0;
        end else begin
            cpu_ack      <= cpu_grant;            // One-cycle pulse
            fetch_served <= fetch_req;
        end
    end

    // Read data to its owner
    assign cpu_rdata  = cpu_ack      ? ram_rdata : '0;
    assign fetch_data = fetch_served ? ram_rdata : '0;

endmodule

// File: design/video_fetch.sv
// Video generator
// Raster counters, bitmap and attribute fetch, pixel shifter, syncs and
// the frame interrupt
`timescale 1ns/1ps

module video_fetch import ula_pkg::*; (
    input  logic       clk_cpu,
    input  logic       reset,
    input  colour_t    border,
    input  byte_t      fetch_data,    // RAM byte, one cycle after fetch_req
    output logic       fetch_req,
    output vram_addr_t fetch_addr,
    output pixel_t     pixel,
    output logic       hs,
    output logic       vs,
    output logic       vs_nintr       // Frame interrupt, active low
);

    logic [8:0]    hcount;            // 0 to 447
    logic [8:0]    vcount;            // 0 to 311
    logic [8:0]    h_next;
    logic [8:0]    v_next;
    vfetch_state_t state;
    logic          attr_issue;        // Bitmap out now, attribute next
    logic          slot_next;         // Next position starts a group
    logic [5:0]    int_count;         // Interrupt clocks left
    byte_t         bitmap_q;
    byte_t         attr_q;
    byte_t         shift_q;           // Pixel shifter, MSB shown
    byte_t         attr_hold;         // Attribute of the group on screen
    logic          in_disp;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster position
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        h_next = hcount + 9'd1;
        v_next = vcount;
        if (hcount == LINE_CLOCKS - 9'd1) begin
            h_next = '0;
            v_next = (vcount == FRAME_LINES - 9'd1) ? 9'd0 : vcount + 9'd1;
        end
    end

    assign slot_next  = (v_next < DISP_H) && (h_next < DISP_W) && (h_next[2:0] == 3'd0);
    assign attr_issue = (state == IDLE) && fetch_req;

    // Control state
    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            hcount    <= '0;
            vcount    <= '0;
            state     <= IDLE;
            fetch_req <= 1'b0;
            int_count <= '0;
        end else begin
            hcount <= h_next;
            vcount <= v_next;
            case (state)
                IDLE:    state <= fetch_req ? BITMAP : IDLE;
                BITMAP:  state <= ATTR;
                default: state <= IDLE;
            endcase
            fetch_req <= attr_issue || slot_next;   // Bitmap at 8k, attr at 8k+1
            // Interrupt starts at line 248, column 0
            if (h_next == 9'd0 && v_next == VSYNC_LINE) begin
                int_count <= INT_CLOCKS;
            end else if (int_count != 6'd0) begin
                int_count <= int_count - 6'd1;
            end
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch address and byte path
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_cpu) begin
        if (attr_issue) begin
            fetch_addr <= ATTR_BASE + vram_addr_t'({vcount[7:3], hcount[7:3]});
        end else begin
            // Thirds, pixel row, char row, column
            fetch_addr <= {v_next[7:6], v_next[2:0], v_next[5:3], h_next[7:3]};
        end
        if (state == BITMAP) bitmap_q <= fetch_data;
        if (state == ATTR)   attr_q   <= fetch_data;
        // Group boundary, gives the 8-clock lag
        if (hcount[2:0] == 3'd7) begin
            shift_q   <= bitmap_q;
            attr_hold <= attr_q;
        end else begin
            shift_q   <= {shift_q[6:0], 1'b0};
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Syncs and colour out
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hs       = (hcount >= HSYNC_START) && (hcount < HSYNC_END);
    assign vs       = (vcount >= VSYNC_LINE) && (vcount < VSYNC_LINE + 9'd4);
    assign vs_nintr = (int_count == 6'd0);

    assign in_disp = (vcount < DISP_H) && (hcount >= PIXEL_LAG)
                     && (hcount < DISP_W + PIXEL_LAG);

    always_comb begin
        if (hs || vs) begin
            pixel = '0;                                 // Blanking
        end else if (in_disp) begin
            // Ink on 1, paper on 0, flash bit ignored
            pixel = {attr_hold[6], shift_q[7] ? attr_hold[2:0] : attr_hold[5:3]};
        end else begin
            pixel = {1'b0, border};
        end
    end

endmodule

// File: design/ula_top.sv
// ULA top level
// Port register, keyboard, video RAM with arbiter and video generator
`timescale 1ns/1ps

module ula_top import ula_pkg::*; (
    input  logic       clk_cpu,
    input  logic       reset,
    // CPU I/O
    input  logic [15:0] A,
    input  byte_t      D,
    input  logic       io_we,
    input  logic       ear_in,
    // Key events
    input  logic       key_event,
    input  key_code_t  key_code,
    input  logic       key_down,
    // CPU video memory access
    input  logic       cpu_req,
    input  logic       cpu_we,
    input  vram_addr_t cpu_addr,
    input  byte_t      cpu_wdata,
    output byte_t      ula_data,
    output logic       ear_out,
    output logic       mic_out,
    output logic       cpu_wait,
    output logic       cpu_ack,
    output byte_t      cpu_rdata,
    // Video out
    output pixel_t     pixel,
    output logic       hs,
    output logic       vs,
    output logic       vs_nintr
);

    key_row_t   key_row;
    colour_t    border;
    logic       fetch_req;
    vram_addr_t fetch_addr;
    byte_t      fetch_data;
    logic       ram_we;
    vram_addr_t ram_addr;
    byte_t      ram_wdata;
    byte_t      ram_rdata;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // I/O side
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ula_port ula_port_ (.*);

    key_matrix key_matrix_ (
        .clk_cpu, .reset, .key_event, .key_code, .key_down,
        .row_select (A[15:8]),        // Upper address byte picks half-rows
        .key_row
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video side
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    vram_arbiter vram_arbiter_ (.*);

    video_ram video_ram_ (
        .clk_cpu,
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    video_fetch video_fetch_ (.*);

endmodule

// File: sim/ula_asserts.sv
// ULA bound assertions
// Arbiter priority, ack pulse, wait, interrupt width and reset levels
`timescale 1ns/1ps

module ula_asserts (
    input logic clk_cpu,
    input logic reset,
    input logic cpu_req,
    input logic cpu_wait,
    input logic cpu_ack,
    input logic fetch_req,
    input logic hs,
    input logic vs,
    input logic vs_nintr
);

    int assert_errors = 0;            // Read by the testbench at the end
    int low_len;                      // Clocks vs_nintr has been low

    always_ff @(posedge clk_cpu) begin
        if (reset || vs_nintr) low_len <= 0;
        else low_len <= low_len + 1;
    end

    // Video owned the RAM last cycle, so no CPU ack now
    a_ack_priority: assert property (@(posedge clk_cpu) disable iff (reset)
        cpu_ack |-> !$past(fetch_req))
        else begin assert_errors++; $error("cpu_ack after a fetch cycle"); end

    a_ack_pulse: assert property (@(posedge clk_cpu) disable iff (reset)
        cpu_ack |=> !cpu_ack)
        else begin assert_errors++; $error("cpu_ack longer than one cycle"); end

    a_wait_req: assert property (@(posedge clk_cpu) disable iff (reset)
        cpu_wait |-> cpu_req)
        else begin assert_errors++; $error("cpu_wait without cpu_req"); end

    a_int_width: assert property (@(posedge clk_cpu) disable iff (reset)
        $rose(vs_nintr) |-> low_len == 32)
        else begin assert_errors++; $error("vs_nintr pulse not 32 clocks"); end

    // Control outputs idle right after a reset edge
    a_reset_levels: assert property (@(posedge clk_cpu)
        $past(reset) |-> (!cpu_ack && !cpu_wait && !fetch_req && !hs && !vs && vs_nintr))
        else begin assert_errors++; $error("control outputs active after reset"); end

endmodule

bind ula_top ula_asserts u_asserts (
    .clk_cpu, .reset, .cpu_req, .cpu_wait, .cpu_ack, .fetch_req, .hs, .vs, .vs_nintr
);

// File: sim/tb_ula.sv
// ULA testbench
// Port, keyboard, CPU memory, contention, frame timing and display pixels
`timescale 1ns/1ps

module tb_ula import ula_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 450000;   // Three frames plus margin
    localparam int FIRST_PIXEL    = 28680;    // vs_nintr fall to pixel (0,0)

    logic clk_cpu = 1'b0, reset;
    logic [15:0] A;
    byte_t D, ula_data, cpu_wdata, cpu_rdata;
    logic io_we, ear_in, key_event, key_down, ear_out, mic_out;
    key_code_t key_code;
    logic cpu_req, cpu_we, cpu_wait, cpu_ack, hs, vs, vs_nintr;
    vram_addr_t cpu_addr;
    pixel_t pixel;

    integer seed = 47752;
    int errors = 0, checks = 0, cycle_count = 0, pos = 0, last_period = 0;
    logic key_state [40];             // 1 = pressed
    byte_t mem_model [8192];

    ula_top DUT (.*);

    always #10 clk_cpu = ~clk_cpu;

    // Run limit
    always @(posedge clk_cpu) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(negedge clk_cpu);
        pos++;                        // Clocks since last vs_nintr fall
    endtask

    task automatic wait_int_fall();
        while (!vs_nintr) next_cycle();
        while (vs_nintr) next_cycle();
        last_period = pos;
        pos = 0;                      // Now at line 248, hcount 0
    endtask

    task automatic wait_until(input int off);
        while (pos < off) next_cycle();
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %-12s %0d errors", name, errors - err_before);
    endtask

    task automatic port_write(input byte_t data);
        A = 16'hFFFE;
        D = data;
        io_we = 1'b1;
        next_cycle();
        io_we = 1'b0;
        next_cycle();
    endtask

    // Holds cpu_req until cpu_ack, counting clocks and any wait
    task automatic cpu_access(input logic we, input vram_addr_t addr, input byte_t wdata,
                              output byte_t rdata, output int latency, output logic waited);
        latency = 0;
        waited  = 1'b0;
        cpu_req = 1'b1;
        cpu_we = we;
        cpu_addr = addr;
        cpu_wdata = wdata;
        while (!cpu_ack && latency < 20) begin
            next_cycle();
            latency++;
            if (cpu_wait) waited = 1'b1;
        end
        if (!cpu_ack) begin
            errors++;
            $display("cpu_ack never arrived for address %0h", addr);
        end
        rdata   = cpu_rdata;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        if (we) mem_model[addr] = wdata;
        next_cycle();                 // Idle while cpu_ack drops
    endtask

    function automatic vram_addr_t bitmap_addr(input logic [7:0] y, input logic [7:0] x);
        return {y[7:6], y[2:0], y[5:3], x[7:3]};
    endfunction

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int eb, lat, aerr, y, x;
        logic [31:0] w;
        logic [7:0] sel;
        logic [4:0] row;
        logic waited;
        byte_t rd, bmp [2][4], att [2][4];
        vram_addr_t addrs [16];
        int ks [4];

        reset = 1'b1;
        A = 16'hFFFF;
        D = '0;
        io_we = 1'b0;
        ear_in = 1'b0;
        key_event = 1'b0;
        key_code = '0;
        key_down = 1'b0;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        ks = '{0, 5, 17, 31};
        for (int i = 0; i < 40; i++) key_state[i] = 1'b0;
        repeat (5) @(negedge clk_cpu);
        reset = 1'b0;

        // 1: port register
        eb = errors;
        for (int i = 0; i < 8; i++) begin
            w = $random(seed);
            port_write(w[7:0]);
            check("port_ear", w[4], ear_out);
            check("port_mic", w[3], mic_out);
        end
        A = 16'h00FF;                 // Odd port
        next_cycle();
        check("port_odd", 8'hFF, ula_data);
        report("port", eb);

        // 2: keyboard
        eb = errors;
        for (int i = 0; i < 24; i++) begin
            w = $random(seed);
            key_code = key_code_t'(w[15:0] % 16'd40);
            key_down = w[20];
            key_event = 1'b1;
            key_state[w[15:0] % 16'd40] = w[20];
            next_cycle();
            key_event = 1'b0;
        end
        for (int i = 0; i < 12; i++) begin
            w = $random(seed);
            sel = (i == 0) ? 8'h00 : (i == 1) ? 8'hFF : w[7:0];
            A = {sel, 8'hFE};
            ear_in = w[8];
            next_cycle();
            row = 5'h1F;
            for (int r = 0; r < 8; r++)
                for (int c = 0; c < 5; c++)
                    if (!sel[r] && key_state[r * 5 + c]) row[c] = 1'b0;
            check("key_read", {1'b1, w[8], 1'b1, row}, ula_data);
        end
        report("keyboard", eb);

        // 3: uncontended CPU memory, in the lower border
        eb = errors;
        wait_int_fall();
        for (int i = 0; i < 16; i++) begin
            w = $random(seed);
            addrs[i] = w[12:0];
            cpu_access(1'b1, addrs[i], w[23:16], rd, lat, waited);
            check("mem_write_latency", 1, lat);
        end
        for (int i = 0; i < 16; i++) begin
            cpu_access(1'b0, addrs[i], 8'h00, rd, lat, waited);
            check("mem_read_data", mem_model[addrs[i]], rd);
            check("mem_read_latency", 1, lat);
        end
        report("cpu_memory", eb);

        // 6: display pixels, bytes loaded before line 0
        eb = errors;
        for (int j = 0; j < 2; j++) begin
            y = (j == 0) ? 0 : 9;
            for (int g = 0; g < 4; g++) begin
                w = $random(seed);
                bmp[j][g] = w[7:0];
                att[j][g] = w[15:8];
                cpu_access(1'b1, bitmap_addr(y, ks[g] * 8), bmp[j][g], rd, lat, waited);
                cpu_access(1'b1, ATTR_BASE + vram_addr_t'((y / 8) * 32 + ks[g]),
                           att[j][g], rd, lat, waited);
            end
        end
        for (int j = 0; j < 2; j++) begin
            y = (j == 0) ? 0 : 9;
            for (int g = 0; g < 4; g++) begin
                for (int b = 0; b < 8; b++) begin
                    x = ks[g] * 8 + b;
                    wait_until(FIRST_PIXEL + y * 448 + x);
                    check("display_pixel", {att[j][g][6], bmp[j][g][7 - b] ?
                          att[j][g][2:0] : att[j][g][5:3]}, pixel);
                end
            end
        end
        report("display", eb);

        // 4: contention on line 50, fetches at hcount 0,1 and 8,9
        eb = errors;
        w = $random(seed);
        wait_until(FIRST_PIXEL - 8 + 50 * 448);
        cpu_access(1'b1, w[12:0], w[23:16], rd, lat, waited);
        check("cont_write_wait", 1, waited);
        check("cont_write_latency", 3, lat);
        wait_until(FIRST_PIXEL + 50 * 448);
        cpu_access(1'b0, w[12:0], 8'h00, rd, lat, waited);
        check("cont_read_wait", 1, waited);
        check("cont_read_data", w[23:16], rd);
        report("contention", eb);

        // 5: border at line 200 column 100, syncs, then interrupt period
        eb = errors;
        w = $random(seed);
        port_write(w[7:0]);
        wait_until((312 - 248 + 200) * 448 + 100);
        check("border_pixel", {1'b0, w[2:0]}, pixel);
        check("hs_idle", 0, hs);
        wait_until((312 - 248 + 200) * 448 + 304);  // First hs column
        check("hs_start", 1, hs);
        check("blank_pixel", 0, pixel);
        wait_until((312 - 248 + 200) * 448 + 336);
        check("hs_end", 0, hs);
        check("vs_idle", 0, vs);
        wait_int_fall();
        check("int_period", 139776, last_period);
        check("vs_start", 1, vs);
        wait_until(4 * 448);                        // Line 252
        check("vs_end", 0, vs);
        report("frame", eb);

        aerr = DUT.u_asserts.assert_errors;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, aerr);
        if (errors == 0 && aerr == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: zx_ula.f
design/ula_pkg.sv
design/ula_port.sv
design/key_matrix.sv
design/video_ram.sv
design/vram_arbiter.sv
design/video_fetch.sv
design/ula_top.sv
sim/ula_asserts.sv
sim/tb_ula.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the ULA testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ula -Mdir obj_dir -o Vtb_ula -f zx_ula.f
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/Vtb_ula | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if grep -Fxq "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
